// File: sources.f
src/id_remap_pkg.sv
src/first_one_finder.sv
src/id_remap_table.sv
src/remap_issue_fsm.sv
src/axi_id_remap.sv
testbench/axi_id_remap_props.sv
testbench/tb_axi_id_remap.sv

// File: Makefile
# Verilator flow for the AXI ID remapper.
TOP := tb_axi_id_remap

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -f sources.f

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	@if grep -qF '** FAIL **' sim.log; then echo "simulation failed"; exit 1; fi
	@grep -qF '** PASS **' sim.log || (echo "simulation ended early"; exit 1)

lint:
	verilator --lint-only --timing -Wall --top-module axi_id_remap -f sources.f

clean:
	rm -rf obj_dir sim.log

// File: testbench/tb_axi_id_remap.sv
/* Slave-side response ready refuses each beat for one cycle before taking it. Responses go
   only to entries that the reference table holds as busy, and direction 0 means reads. */
`timescale 1ns/1ps

module tb_axi_id_remap import id_remap_pkg::*; ();

  localparam int WAIT_LIMIT = 20;

  logic    clk_i;
  logic    arst_n_i;
  logic    slv_ar_valid_i, slv_ar_ready_o, mst_ar_valid_o, mst_ar_ready_i;
  slv_id_t slv_ar_id_i;
  addr_t   slv_ar_addr_i, mst_ar_addr_o;
  mst_id_t mst_ar_id_o;
  logic    slv_aw_valid_i, slv_aw_ready_o, mst_aw_valid_o, mst_aw_ready_i;
  slv_id_t slv_aw_id_i;
  addr_t   slv_aw_addr_i, mst_aw_addr_o;
  mst_id_t mst_aw_id_o;
  logic    mst_r_valid_i, mst_r_ready_o, mst_r_last_i;
  logic    slv_r_valid_o, slv_r_ready_i, slv_r_last_o;
  mst_id_t mst_r_id_i;
  slv_id_t slv_r_id_o;
  logic    mst_b_valid_i, mst_b_ready_o, slv_b_valid_o, slv_b_ready_i;
  mst_id_t mst_b_id_i;
  slv_id_t slv_b_id_o;

  // Reference tables, one row per direction.
  slv_id_t ref_id  [2][MAX_UNIQ_IDS];
  int      ref_cnt [2][MAX_UNIQ_IDS];
  // Index that a stalled request is expected to keep.
  int      held_idx [2];
  integer  seed;
  int      errors;
  int      checks;
  int      tests;
  int      test_errors;
  string   test_name;

  axi_id_remap uut (.*);

  bind axi_id_remap axi_id_remap_props props (.*);

  always #20 clk_i = ~clk_i;

  // An in-flight ID keeps its entry up to its limit.
  // A new ID takes the lowest free entry, and -1 means that the request has to wait.
  function automatic int predict_idx(input int dir, input slv_id_t id);
    int free_idx;
    free_idx = -1;
    for (int i = int'(MAX_UNIQ_IDS) - 1; i >= 0; i--) begin
      if (ref_cnt[dir][i] == 0) begin
        free_idx = i;
      end
    end
    for (int i = 0; i < int'(MAX_UNIQ_IDS); i++) begin
      if (ref_cnt[dir][i] != 0 && ref_id[dir][i] == id) begin
        return (ref_cnt[dir][i] < int'(MAX_TXNS_PER_ID)) ? i : -1;
      end
    end
    return free_idx;
  endfunction

  function automatic logic fwd_valid(input int dir);
    return (dir == 0) ? mst_ar_valid_o : mst_aw_valid_o;
  endfunction

  function automatic logic fwd_slv_ready(input int dir);
    return (dir == 0) ? slv_ar_ready_o : slv_aw_ready_o;
  endfunction

  function automatic int fwd_id(input int dir);
    return (dir == 0) ? int'(mst_ar_id_o) : int'(mst_aw_id_o);
  endfunction

  function automatic int fwd_addr(input int dir);
    return (dir == 0) ? int'(mst_ar_addr_o) : int'(mst_aw_addr_o);
  endfunction

  task automatic check(input string what, input int exp, input int act);
    checks++;
    assert (exp == act) else begin
      errors++;
      $display("mismatch in %s, %s: expected %0d, actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic step();
    @(posedge clk_i);
    #2;
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = errors;
  endtask

  task automatic finish_test();
    tests++;
    if (errors == test_errors) begin
      $display("test %s: ok", test_name);
    end else begin
      $display("test %s: %0d errors", test_name, errors - test_errors);
    end
  endtask

  task automatic end_run();
    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
             tests, checks, errors, uut.props.fail_cnt);
    if (errors == 0 && uut.props.fail_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  task automatic abort_on_timeout(input string what);
    errors++;
    $display("timeout in %s while waiting for %s", test_name, what);
    end_run();
  endtask

  task automatic set_req(input int dir, input logic valid, input slv_id_t id, input addr_t addr,
                         input logic rdy);
    if (dir == 0) begin
      slv_ar_valid_i = valid;
      slv_ar_id_i    = id;
      slv_ar_addr_i  = addr;
      mst_ar_ready_i = rdy;
    end else begin
      slv_aw_valid_i = valid;
      slv_aw_id_i    = id;
      slv_aw_addr_i  = addr;
      mst_aw_ready_i = rdy;
    end
  endtask

  // Presents one request with the given master ready and waits until it is forwarded.
  task automatic request(input int dir, input slv_id_t id, input logic rdy);
    int    exp_idx;
    int    t;
    addr_t addr;
    addr = addr_t'($random(seed));
    t    = 0;
    set_req(dir, 1'b1, id, addr, rdy);
    #1;
    while (!fwd_valid(dir) && t < WAIT_LIMIT) begin
      // The reference must agree that the waiting request is not admissible.
      check("admission, -1 is wait", -1, predict_idx(dir, id));
      check("slave ready while waiting", 0, int'(fwd_slv_ready(dir)));
      step();
      #1;
      t++;
    end
    if (t >= WAIT_LIMIT) begin
      abort_on_timeout("a forwarded request");
    end else begin
      exp_idx = predict_idx(dir, id);
      check("master id", exp_idx, fwd_id(dir));
      check("master addr", int'(addr), fwd_addr(dir));
      check("slave ready", int'(rdy), int'(fwd_slv_ready(dir)));
      step();
      // The entry is taken at this edge even if the master stalled.
      if (exp_idx >= 0) begin
        ref_id[dir][exp_idx] = id;
        ref_cnt[dir][exp_idx]++;
      end
      held_idx[dir] = exp_idx;
      if (rdy) begin
        set_req(dir, 1'b0, id, addr, 1'b1);
      end
    end
  endtask

  // Raises master ready on a held channel after checking that the request was kept.
  task automatic end_hold(input int dir);
    check("held valid", 1, int'(fwd_valid(dir)));
    check("held id", held_idx[dir], fwd_id(dir));
    if (dir == 0) begin
      mst_ar_ready_i = 1'b1;
    end else begin
      mst_aw_ready_i = 1'b1;
    end
    #1;
    check("slave ready at end of hold", 1, int'(fwd_slv_ready(dir)));
    step();
    if (dir == 0) begin
      slv_ar_valid_i = 1'b0;
    end else begin
      slv_aw_valid_i = 1'b0;
    end
  endtask

  // Returns one response beat for a busy entry and checks the restored slave ID.
  // The slave refuses the beat for one cycle first, which must not free the entry.
  task automatic respond(input int dir, input int idx, input logic last);
    if (dir == 0) begin
      mst_r_valid_i = 1'b1;
      mst_r_id_i    = mst_id_t'(idx);
      mst_r_last_i  = last;
      slv_r_ready_i = 1'b0;
    end else begin
      mst_b_valid_i = 1'b1;
      mst_b_id_i    = mst_id_t'(idx);
      slv_b_ready_i = 1'b0;
    end
    step();
    slv_r_ready_i = 1'b1;
    slv_b_ready_i = 1'b1;
    #1;
    check("response id", int'(ref_id[dir][idx]), int'((dir == 0) ? slv_r_id_o : slv_b_id_o));
    step();
    // Reads free their entry with the last beat only.
    if (dir == 1 || last) begin
      ref_cnt[dir][idx]--;
    end
    mst_r_valid_i = 1'b0;
    mst_r_last_i  = 1'b0;
    mst_b_valid_i = 1'b0;
  endtask

  // Completes everything in flight so the next test starts from empty tables.
  task automatic drain();
    for (int d = 0; d < 2; d++) begin
      for (int i = 0; i < int'(MAX_UNIQ_IDS); i++) begin
        while (ref_cnt[d][i] > 0) begin
          respond(d, i, 1'b1);
        end
      end
    end
  endtask

  task automatic random_mix(input int n);
    int      dir;
    int      op;
    int      idx;
    slv_id_t id;
    logic    rdy;
    for (int k = 0; k < n; k++) begin
      dir = int'($unsigned($random(seed)) % 2);
      op  = int'($unsigned($random(seed)) % 3);
      idx = int'($unsigned($random(seed)) % MAX_UNIQ_IDS);
      id  = slv_id_t'($random(seed));
      rdy = 1'($random(seed));
      // Only admissible requests are issued, so a stall here is a disagreement.
      if (op != 0 && predict_idx(dir, id) >= 0) begin
        request(dir, id, rdy);
        if (!rdy) begin
          step();
          end_hold(dir);
        end
      end else if (ref_cnt[dir][idx] > 0) begin
        respond(dir, idx, (dir == 1) || 1'($random(seed)));
      end
    end
    drain();
  endtask

  initial begin
    seed           = 32'h2bb1d068;
    errors         = 0;
    checks         = 0;
    tests          = 0;
    clk_i          = 1'b0;
    arst_n_i       = 1'b0;
    set_req(0, 1'b0, '0, '0, 1'b1);
    set_req(1, 1'b0, '0, '0, 1'b1);
    mst_r_valid_i  = 1'b0;
    mst_r_id_i     = '0;
    mst_r_last_i   = 1'b0;
    slv_r_ready_i  = 1'b1;
    mst_b_valid_i  = 1'b0;
    mst_b_id_i     = '0;
    slv_b_ready_i  = 1'b1;
    held_idx[0]    = 0;
    held_idx[1]    = 0;
    for (int i = 0; i < int'(MAX_UNIQ_IDS); i++) begin
      ref_id[0][i]  = '0;
      ref_id[1][i]  = '0;
      ref_cnt[0][i] = 0;
      ref_cnt[1][i] = 0;
    end

    start_test("reset");
    repeat (3) @(posedge clk_i);
    #2;
    check("ar valid in reset", 0, int'(mst_ar_valid_o));
    check("aw valid in reset", 0, int'(mst_aw_valid_o));
    arst_n_i = 1'b1;
    finish_test();

    start_test("alloc_order");
    request(0, 4'hA, 1'b1);
    request(0, 4'h3, 1'b1);
    request(0, 4'hE, 1'b1);
    request(0, 4'h6, 1'b1);
    respond(0, 1, 1'b1);
    request(0, 4'hF, 1'b1);
    drain();
    finish_test();

    start_test("id_reuse");
    repeat (3) request(0, 4'h5, 1'b1);
    fork
      request(0, 4'h5, 1'b1);
      begin
        step();
        step();
        respond(0, 0, 1'b1);
      end
    join
    drain();
    finish_test();

    start_test("table_full");
    request(0, 4'h1, 1'b1);
    request(0, 4'h2, 1'b1);
    request(0, 4'h3, 1'b1);
    request(0, 4'h4, 1'b1);
    fork
      request(0, 4'h9, 1'b1);
      begin
        step();
        respond(0, 2, 1'b0);
        step();
        respond(0, 2, 1'b1);
      end
    join
    drain();
    finish_test();

    start_test("response_ids");
    request(1, 4'hC, 1'b1);
    request(1, 4'h7, 1'b1);
    request(0, 4'h6, 1'b1);
    respond(1, 1, 1'b1);
    respond(0, 0, 1'b0);
    respond(0, 0, 1'b1);
    respond(1, 0, 1'b1);
    finish_test();

    start_test("hold_both");
    // Busy entries in front make the held indices differ from their reset value and from
    // each other.
    request(0, 4'h2, 1'b1);
    request(1, 4'h8, 1'b1);
    request(1, 4'h9, 1'b1);
    fork
      request(0, 4'hB, 1'b0);
      request(1, 4'hD, 1'b0);
    join
    step();
    step();
    end_hold(0);
    step();
    end_hold(1);
    drain();
    finish_test();

    start_test("random_mix");
    random_mix(300);
    finish_test();

    end_run();
  end

endmodule

// File: testbench/axi_id_remap_props.sv
/* Bound into axi_id_remap. All properties are disabled while reset is asserted. */
`timescale 1ns/1ps

module axi_id_remap_props import id_remap_pkg::*; (
  input logic    clk_i,
  input logic    arst_n_i,
  input logic    slv_ar_valid_i,
  input logic    slv_ar_ready_o,
  input logic    mst_ar_valid_o,
  input logic    mst_ar_ready_i,
  input mst_id_t mst_ar_id_o,
  input logic    slv_aw_valid_i,
  input logic    slv_aw_ready_o,
  input logic    mst_aw_valid_o,
  input logic    mst_aw_ready_i,
  input mst_id_t mst_aw_id_o,
  input logic    mst_r_valid_i,
  input logic    mst_r_ready_o,
  input logic    mst_r_last_i,
  input logic    slv_r_valid_o,
  input logic    slv_r_ready_i,
  input logic    slv_r_last_o,
  input logic    mst_b_valid_i,
  input logic    mst_b_ready_o,
  input logic    slv_b_valid_o,
  input logic    slv_b_ready_i
);

  int fail_cnt = 0;

  task automatic flag_error(input string msg);
    fail_cnt++;
    $error("%s", msg);
  endtask

  // A slave-side handshake is only possible together with the master-side handshake.
  ar_accept: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      slv_ar_valid_i && slv_ar_ready_o |-> mst_ar_valid_o && mst_ar_ready_i)
    else flag_error("AR accepted at the slave port without a master accept");
  aw_accept: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      slv_aw_valid_i && slv_aw_ready_o |-> mst_aw_valid_o && mst_aw_ready_i)
    else flag_error("AW accepted at the slave port without a master accept");

  // Responses only have their ID translated; the rest are plain wires.
  r_pass: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      slv_r_valid_o == mst_r_valid_i && mst_r_ready_o == slv_r_ready_i &&
      slv_r_last_o == mst_r_last_i)
    else flag_error("R valid, ready or last not passed through");
  b_pass: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      slv_b_valid_o == mst_b_valid_i && mst_b_ready_o == slv_b_ready_i)
    else flag_error("B valid or ready not passed through");

  // A forwarded request that the master stalls keeps its valid and its output ID.
  ar_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      mst_ar_valid_o && !mst_ar_ready_i |=> mst_ar_valid_o && $stable(mst_ar_id_o))
    else flag_error("AR valid or ID changed while the master stalled");
  aw_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      mst_aw_valid_o && !mst_aw_ready_i |=> mst_aw_valid_o && $stable(mst_aw_id_o))
    else flag_error("AW valid or ID changed while the master stalled");

  // The slave never sees ready for a request that was not forwarded.
  ar_no_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      slv_ar_valid_i && !mst_ar_valid_o |-> !slv_ar_ready_o)
    else flag_error("AR slave ready raised while master valid was low");
  aw_no_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      slv_aw_valid_i && !mst_aw_valid_o |-> !slv_aw_ready_o)
    else flag_error("AW slave ready raised while master valid was low");

endmodule

// File: src/axi_id_remap.sv
/* Only address, ID, R last and the handshakes are carried. Reads free an entry on the last
   R beat only, and writes free one on every B beat. */
`timescale 1ns/1ps

module axi_id_remap import id_remap_pkg::*; (
  input  logic    clk_i,
  input  logic    arst_n_i,
  // Read address.
  input  logic    slv_ar_valid_i,
  output logic    slv_ar_ready_o,
  input  slv_id_t slv_ar_id_i,
  input  addr_t   slv_ar_addr_i,
  output logic    mst_ar_valid_o,
  input  logic    mst_ar_ready_i,
  output mst_id_t mst_ar_id_o,
  output addr_t   mst_ar_addr_o,
  // Read response.
  input  logic    mst_r_valid_i,
  output logic    mst_r_ready_o,
  input  mst_id_t mst_r_id_i,
  input  logic    mst_r_last_i,
  output logic    slv_r_valid_o,
  input  logic    slv_r_ready_i,
  output slv_id_t slv_r_id_o,
  output logic    slv_r_last_o,
  // Write address.
  input  logic    slv_aw_valid_i,
  output logic    slv_aw_ready_o,
  input  slv_id_t slv_aw_id_i,
  input  addr_t   slv_aw_addr_i,
  output logic    mst_aw_valid_o,
  input  logic    mst_aw_ready_i,
  output mst_id_t mst_aw_id_o,
  output addr_t   mst_aw_addr_o,
  // Write response.
  input  logic    mst_b_valid_i,
  output logic    mst_b_ready_o,
  input  mst_id_t mst_b_id_i,
  output logic    slv_b_valid_o,
  input  logic    slv_b_ready_i,
  output slv_id_t slv_b_id_o
);

  logic rd_full, rd_exists, rd_exists_full, rd_push, rd_pop;
  logic wr_full, wr_exists, wr_exists_full, wr_push, wr_pop;
  idx_t rd_free_idx, rd_exists_idx, rd_idx;
  idx_t wr_free_idx, wr_exists_idx, wr_idx;

  // Addresses and response flow control are not touched by the remapping.
  assign mst_ar_addr_o = slv_ar_addr_i;
  assign mst_aw_addr_o = slv_aw_addr_i;
  assign slv_r_valid_o = mst_r_valid_i;
  assign mst_r_ready_o = slv_r_ready_i;
  assign slv_r_last_o  = mst_r_last_i;
  assign slv_b_valid_o = mst_b_valid_i;
  assign mst_b_ready_o = slv_b_ready_i;

  // A burst leaves the read table only with its final beat.
  assign rd_pop = mst_r_valid_i && slv_r_ready_i && mst_r_last_i;
  assign wr_pop = mst_b_valid_i && slv_b_ready_i;

  // Master IDs are the table index with zeros prepended.
  assign mst_ar_id_o = {{(MST_ID_W - IDX_W){1'b0}}, rd_idx};
  assign mst_aw_id_o = {{(MST_ID_W - IDX_W){1'b0}}, wr_idx};

  id_remap_table rd_table (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .free_idx_o    (rd_free_idx),
    .full_o        (rd_full),
    .push_i        (rd_push),
    .push_inp_id_i (slv_ar_id_i),
    .push_idx_i    (rd_idx),
    .lookup_id_i   (slv_ar_id_i),
    .exists_o      (rd_exists),
    .exists_idx_o  (rd_exists_idx),
    .exists_full_o (rd_exists_full),
    .pop_i         (rd_pop),
    .pop_idx_i     (mst_r_id_i[IDX_W-1:0]),
    .pop_inp_id_o  (slv_r_id_o)
  );

  id_remap_table wr_table (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .free_idx_o    (wr_free_idx),
    .full_o        (wr_full),
    .push_i        (wr_push),
    .push_inp_id_i (slv_aw_id_i),
    .push_idx_i    (wr_idx),
    .lookup_id_i   (slv_aw_id_i),
    .exists_o      (wr_exists),
    .exists_idx_o  (wr_exists_idx),
    .exists_full_o (wr_exists_full),
    .pop_i         (wr_pop),
    .pop_idx_i     (mst_b_id_i[IDX_W-1:0]),
    .pop_inp_id_o  (slv_b_id_o)
  );

  remap_issue_fsm issue_fsm (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .slv_ar_valid_i   (slv_ar_valid_i),
    .mst_ar_ready_i   (mst_ar_ready_i),
    .mst_ar_valid_o   (mst_ar_valid_o),
    .slv_ar_ready_o   (slv_ar_ready_o),
    .rd_exists_i      (rd_exists),
    .rd_exists_full_i (rd_exists_full),
    .rd_exists_idx_i  (rd_exists_idx),
    .rd_full_i        (rd_full),
    .rd_free_idx_i    (rd_free_idx),
    .rd_push_o        (rd_push),
    .rd_idx_o         (rd_idx),
    .slv_aw_valid_i   (slv_aw_valid_i),
    .mst_aw_ready_i   (mst_aw_ready_i),
    .mst_aw_valid_o   (mst_aw_valid_o),
    .slv_aw_ready_o   (slv_aw_ready_o),
    .wr_exists_i      (wr_exists),
    .wr_exists_full_i (wr_exists_full),
    .wr_exists_idx_i  (wr_exists_idx),
    .wr_full_i        (wr_full),
    .wr_free_idx_i    (wr_free_idx),
    .wr_push_o        (wr_push),
    .wr_idx_o         (wr_idx)
  );

endmodule

// File: src/remap_issue_fsm.sv
/* A request in READY is pushed to its table at once, even if the master stalls it. While one
   channel is held, the other channel accepts nothing until the machine is back in READY. */
`timescale 1ns/1ps

module remap_issue_fsm import id_remap_pkg::*; (
  input  logic clk_i,
  input  logic arst_n_i,
  // Read address handshake.
  input  logic slv_ar_valid_i,
  input  logic mst_ar_ready_i,
  output logic mst_ar_valid_o,
  output logic slv_ar_ready_o,
  // Read table.
  input  logic rd_exists_i,
  input  logic rd_exists_full_i,
  input  idx_t rd_exists_idx_i,
  input  logic rd_full_i,
  input  idx_t rd_free_idx_i,
  output logic rd_push_o,
  output idx_t rd_idx_o,
  // Write address handshake.
  input  logic slv_aw_valid_i,
  input  logic mst_aw_ready_i,
  output logic mst_aw_valid_o,
  output logic slv_aw_ready_o,
  // Write table.
  input  logic wr_exists_i,
  input  logic wr_exists_full_i,
  input  idx_t wr_exists_idx_i,
  input  logic wr_full_i,
  input  idx_t wr_free_idx_i,
  output logic wr_push_o,
  output idx_t wr_idx_o
);

  remap_state_e state_q, state_d;
  idx_t         ar_id_q, ar_id_d;
  idx_t         aw_id_q, aw_id_d;

  logic rd_ok, wr_ok;
  logic rd_stall, wr_stall;
  idx_t rd_sel_idx, wr_sel_idx;

  // A request is admissible when its ID is in flight below the limit,
  // or when it is new and a free entry is left.
  assign rd_ok = slv_ar_valid_i &&
                 ((rd_exists_i && !rd_exists_full_i) || (!rd_exists_i && !rd_full_i));
  assign wr_ok = slv_aw_valid_i &&
                 ((wr_exists_i && !wr_exists_full_i) || (!wr_exists_i && !wr_full_i));

  // Reusing the existing index keeps same-ID transactions in order.
  assign rd_sel_idx = rd_exists_i ? rd_exists_idx_i : rd_free_idx_i;
  assign wr_sel_idx = wr_exists_i ? wr_exists_idx_i : wr_free_idx_i;

  // A forwarded request that the master does not take this cycle must be held.
  assign rd_stall = rd_ok && !mst_ar_ready_i;
  assign wr_stall = wr_ok && !mst_aw_ready_i;

  always_comb begin
    mst_ar_valid_o = 1'b0;
    slv_ar_ready_o = 1'b0;
    rd_push_o      = 1'b0;
    rd_idx_o       = ar_id_q;
    mst_aw_valid_o = 1'b0;
    slv_aw_ready_o = 1'b0;
    wr_push_o      = 1'b0;
    wr_idx_o       = aw_id_q;
    ar_id_d        = ar_id_q;
    aw_id_d        = aw_id_q;
    state_d        = state_q;

    unique case (state_q)
      READY: begin
        rd_idx_o = rd_sel_idx;
        wr_idx_o = wr_sel_idx;
        // The slave sees the master's ready in the same cycle.
        if (rd_ok) begin
          mst_ar_valid_o = 1'b1;
          slv_ar_ready_o = mst_ar_ready_i;
          rd_push_o      = 1'b1;
        end
        if (wr_ok) begin
          mst_aw_valid_o = 1'b1;
          slv_aw_ready_o = mst_aw_ready_i;
          wr_push_o      = 1'b1;
        end
        // Store the index of each stalled channel so it stays stable.
        if (rd_stall) begin
          ar_id_d = rd_sel_idx;
        end
        if (wr_stall) begin
          aw_id_d = wr_sel_idx;
        end
        unique case ({rd_stall, wr_stall})
          2'b11:   state_d = HOLD_AX;
          2'b10:   state_d = HOLD_AR;
          2'b01:   state_d = HOLD_AW;
          default: state_d = READY;
        endcase
      end

      HOLD_AR: begin
        mst_ar_valid_o = 1'b1;
        slv_ar_ready_o = mst_ar_ready_i;
        if (mst_ar_ready_i) begin
          state_d = READY;
        end
      end

      HOLD_AW: begin
        mst_aw_valid_o = 1'b1;
        slv_aw_ready_o = mst_aw_ready_i;
        if (mst_aw_ready_i) begin
          state_d = READY;
        end
      end

      HOLD_AX: begin
        mst_ar_valid_o = 1'b1;
        slv_ar_ready_o = mst_ar_ready_i;
        mst_aw_valid_o = 1'b1;
        slv_aw_ready_o = mst_aw_ready_i;
        // Whichever channel completes first leaves the other one held.
        unique case ({mst_ar_ready_i, mst_aw_ready_i})
          2'b11:   state_d = READY;
          2'b10:   state_d = HOLD_AW;
          2'b01:   state_d = HOLD_AR;
          default: state_d = HOLD_AX;
        endcase
      end

      default: state_d = READY;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= READY;
      ar_id_q <= '0;
      aw_id_q <= '0;
    end else begin
      state_q <= state_d;
      ar_id_q <= ar_id_d;
      aw_id_q <= aw_id_d;
    end
  end

endmodule

// File: src/id_remap_table.sv
/* Pushes must target a free entry or the entry that already holds the same input ID, below
   the per-ID limit. Pops must target a busy entry. The caller enforces both. */
`timescale 1ns/1ps

module id_remap_table import id_remap_pkg::*; (
  input  logic    clk_i,
  input  logic    arst_n_i,
  // Lowest free entry and table-full flag.
  output idx_t    free_idx_o,
  output logic    full_o,
  // Push of a new transaction.
  input  logic    push_i,
  input  slv_id_t push_inp_id_i,
  input  idx_t    push_idx_i,
  // Lookup of an incoming input ID.
  input  slv_id_t lookup_id_i,
  output logic    exists_o,
  output idx_t    exists_idx_o,
  output logic    exists_full_o,
  // Pop on a completed response.
  input  logic    pop_i,
  input  idx_t    pop_idx_i,
  output slv_id_t pop_inp_id_o
);

  // Each entry pairs an input ID with the number of its transactions in flight.
  slv_id_t                  inp_id_q [MAX_UNIQ_IDS];
  cnt_t [MAX_UNIQ_IDS-1:0]  cnt_q;

  field_t free;
  field_t match;
  field_t inc;
  field_t dec;
  logic   no_match;

  for (genvar i = 0; i < MAX_UNIQ_IDS; i++) begin : gen_entry
    // An entry with a zero count is available for a new input ID.
    assign free[i]  = (cnt_q[i] == '0);
    // Only busy entries can match, since the stored ID of a free entry is stale.
    assign match[i] = (cnt_q[i] != '0) && (inp_id_q[i] == lookup_id_i);
    assign inc[i]   = push_i && (push_idx_i == idx_t'(i));
    assign dec[i]   = pop_i && (pop_idx_i == idx_t'(i));
  end

  // Lowest free entry for allocation.
  first_one_finder free_finder (
    .vec_i  (free),
    .idx_o  (free_idx_o),
    .none_o (full_o)
  );

  // At most one entry matches, because an input ID is only ever stored in one busy entry.
  first_one_finder match_finder (
    .vec_i  (match),
    .idx_o  (exists_idx_o),
    .none_o (no_match)
  );

  assign exists_o      = !no_match;
  assign exists_full_o = (cnt_q[exists_idx_o] == cnt_t'(MAX_TXNS_PER_ID));

  // The response path reads back the input ID of the returned index.
  assign pop_inp_id_o = inp_id_q[pop_idx_i];

  // A push and a pop on the same entry in one cycle cancel out.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < MAX_UNIQ_IDS; i++) begin
        if (inc[i] && !dec[i]) begin
          cnt_q[i] <= cnt_q[i] + cnt_t'(1);
        end else if (dec[i] && !inc[i]) begin
          cnt_q[i] <= cnt_q[i] - cnt_t'(1);
        end
      end
    end
  end

  // Rewriting the ID of an existing entry stores the same value again.
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      inp_id_q[push_idx_i] <= push_inp_id_i;
    end
  end

endmodule

// File: src/first_one_finder.sv
/* Purely combinational. idx_o reads zero when no bit is set, so check none_o first. */
`timescale 1ns/1ps

module first_one_finder import id_remap_pkg::*; (
  input  field_t vec_i,
  output idx_t   idx_o,
  output logic   none_o
);

  // Set once the scan has passed the first set bit.
  logic found;

  // Entry 0 has the highest priority.
  // Later set bits are ignored once one has been found.
  always_comb begin
    idx_o = '0;
    found = 1'b0;
    for (int i = 0; i < MAX_UNIQ_IDS; i++) begin
      if (vec_i[i] && !found) begin
        idx_o = idx_t'(i);
        found = 1'b1;
      end
    end
  end

  // An all-zero vector means no entry qualifies.
  assign none_o = !found;

endmodule

// File: src/id_remap_pkg.sv
/* Fixed widths and limits of the ID remapper. MAX_UNIQ_IDS is assumed to be a power of two,
   and MST_ID_W must be at least IDX_W because master IDs are zero-extended table indices. */
package id_remap_pkg;

  // Slave-port IDs are wide and only sparsely used.
  localparam int unsigned SLV_ID_W        = 4;
  // Number of table entries, i.e. distinct input IDs in flight per direction.
  localparam int unsigned MAX_UNIQ_IDS    = 4;
  // An input ID stalls once this many of its transactions are outstanding.
  localparam int unsigned MAX_TXNS_PER_ID = 3;
  // Width of a table index, which is the output ID before zero extension.
  localparam int unsigned IDX_W           = $clog2(MAX_UNIQ_IDS);
  // Master-port IDs carry one zero bit above the index.
  localparam int unsigned MST_ID_W        = 3;
  localparam int unsigned ADDR_W          = 16;
  // A counter must be able to hold the value MAX_TXNS_PER_ID itself.
  localparam int unsigned CNT_W           = $clog2(MAX_TXNS_PER_ID + 1);

  typedef logic [SLV_ID_W-1:0]     slv_id_t;
  typedef logic [MST_ID_W-1:0]     mst_id_t;
  typedef logic [IDX_W-1:0]        idx_t;
  // One bit per table entry.
  typedef logic [MAX_UNIQ_IDS-1:0] field_t;
  typedef logic [CNT_W-1:0]        cnt_t;
  typedef logic [ADDR_W-1:0]       addr_t;

  // States of the issue machine.
  // In a hold state the stalled channel keeps its stored output ID until master ready rises.
  typedef enum logic [1:0] {
    READY,
    HOLD_AR,
    HOLD_AW,
    HOLD_AX
  } remap_state_e;

endpackage
